// ==== Makefile ====
TOOL      := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := glb_top_tb
FILE_LIST := build.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Done: errors found
PASS_MSG  := Done: no errors
SOURCES   := $(wildcard verilog/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

$(SIM): $(FILE_LIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

test: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test did not finish"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
+incdir+verif
verilog/global_buffer_pkg.sv
verilog/glb_core_strm_router.sv
verilog/glb_bank.sv
verilog/glb_core_rd_ctrl.sv
verilog/glb_core_pkt_merge.sv
verilog/glb_top.sv
verif/glb_top_tb.sv

// ==== verif/glb_top_tb_cases.svh ====
`ifndef GLB_TOP_TB_CASES_SVH
`define GLB_TOP_TB_CASES_SVH

// one host packet per row
typedef struct {
    string                    name;
    // active tiles for this row
    int                       chain_len;
    // clk_en low cycles while the packet is in flight
    int                       stall;
    bit                       wr_en;
    global_buffer_pkg::addr_t wr_addr;
    global_buffer_pkg::data_t wr_data;
    bit                       rd_en;
    global_buffer_pkg::addr_t rd_addr;
    // random write data, and expected read data taken from the model
    bit                       rnd;
    // expected host side result
    bit                       exp_wr_en;
    bit                       exp_rd_en;
    bit                       exp_valid;
    global_buffer_pkg::data_t exp_data;
} case_t;

localparam int NUM_ROWS = 24;

case_t cases [NUM_ROWS];

// columns: name, chain, stall, wr_en, wr_addr, wr_data, rd_en, rd_addr, rnd,
//          exp wr_en, exp rd_en, exp rd_data_valid, exp rd_data
task automatic load_cases();
    // write then read back, one word in each tile
    cases[0]  = '{"wr_t0", 4, 0, 1, 12'h010, 16'ha5a5, 0, '0, 0, 0, 0, 0, '0};
    cases[1]  = '{"rd_t0", 4, 0, 0, '0, '0, 1, 12'h010, 0, 0, 0, 1, 16'ha5a5};
    cases[2]  = '{"wr_t1", 4, 0, 1, 12'h120, '0, 0, '0, 1, 0, 0, 0, '0};
    cases[3]  = '{"rd_t1", 4, 0, 0, '0, '0, 1, 12'h120, 1, 0, 0, 1, '0};
    cases[4]  = '{"wr_t2", 4, 0, 1, 12'h233, 16'h0f0f, 0, '0, 0, 0, 0, 0, '0};
    cases[5]  = '{"rd_t2", 4, 0, 0, '0, '0, 1, 12'h233, 0, 0, 0, 1, 16'h0f0f};
    cases[6]  = '{"wr_t3", 4, 0, 1, 12'h3ff, '0, 0, '0, 1, 0, 0, 0, '0};
    cases[7]  = '{"rd_t3", 4, 0, 0, '0, '0, 1, 12'h3ff, 1, 0, 0, 1, '0};
    // round trip for each chain length, owner is the last active tile
    cases[8]  = '{"lat_len1", 1, 0, 0, '0, '0, 1, 12'h010, 0, 0, 0, 1, 16'ha5a5};
    cases[9]  = '{"lat_len2", 2, 0, 0, '0, '0, 1, 12'h120, 1, 0, 0, 1, '0};
    cases[10] = '{"lat_len3", 3, 0, 0, '0, '0, 1, 12'h233, 0, 0, 0, 1, 16'h0f0f};
    cases[11] = '{"lat_len4", 4, 0, 0, '0, '0, 1, 12'h3ff, 1, 0, 0, 1, '0};
    // tile 3 outside a two tile chain, request comes back untouched
    cases[12] = '{"far_rd", 2, 0, 0, '0, '0, 1, 12'h3ff, 0, 0, 1, 0, '0};
    cases[13] = '{"far_wr", 2, 0, 1, 12'h3ff, 16'hdead, 0, '0, 0, 1, 0, 0, '0};
    // so the word in tile 3 is still the old one
    cases[14] = '{"far_keep", 4, 0, 0, '0, '0, 1, 12'h3ff, 1, 0, 0, 1, '0};
    // write and read of one word in one packet, read sees old data
    cases[15] = '{"rmw_t2", 4, 0, 1, 12'h233, 16'h5555, 1, 12'h233, 0, 0, 0, 1, 16'h0f0f};
    cases[16] = '{"rmw_t2_new", 4, 0, 0, '0, '0, 1, 12'h233, 0, 0, 0, 1, 16'h5555};
    cases[17] = '{"rmw_t1", 4, 0, 1, 12'h120, '0, 1, 12'h120, 1, 0, 0, 1, '0};
    cases[18] = '{"rmw_t1_new", 4, 0, 0, '0, '0, 1, 12'h120, 1, 0, 0, 1, '0};
    // frozen chain, later result with the same value
    cases[19] = '{"stall_rd", 4, 3, 0, '0, '0, 1, 12'h010, 0, 0, 0, 1, 16'ha5a5};
    cases[20] = '{"stall_wr", 4, 4, 1, 12'h101, 16'h2222, 0, '0, 0, 0, 0, 0, '0};
    cases[21] = '{"stall_new", 4, 0, 0, '0, '0, 1, 12'h101, 0, 0, 0, 1, 16'h2222};
    cases[22] = '{"stall_far", 2, 2, 1, 12'h200, 16'h1111, 0, '0, 0, 1, 0, 0, '0};
    cases[23] = '{"stall_len1", 1, 5, 0, '0, '0, 1, 12'h010, 0, 0, 0, 1, 16'ha5a5};
endtask

`endif

// ==== verif/glb_top_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module glb_top_tb;

    localparam int NUM_TILES = 4;
    localparam int CLK_HALF = 2;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES = 20;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int SEED = 24271;

    logic                        clk;
    logic                        reset;
    logic                        clk_en;
    global_buffer_pkg::tile_id_t cfg_chain_len;
    logic                        host_wr_en;
    global_buffer_pkg::addr_t    host_wr_addr;
    global_buffer_pkg::data_t    host_wr_data;
    logic                        host_rd_en;
    global_buffer_pkg::addr_t    host_rd_addr;
    logic                        out_wr_en;
    global_buffer_pkg::addr_t    out_wr_addr;
    global_buffer_pkg::data_t    out_wr_data;
    logic                        out_rd_en;
    global_buffer_pkg::addr_t    out_rd_addr;
    logic                        out_rd_data_valid;
    global_buffer_pkg::data_t    out_rd_data;

    // error tallies by kind
    int data_errors;
    int flag_errors;
    int latency_errors;
    int other_errors;

    // reference memory, full address to last word written
    global_buffer_pkg::data_t model_mem [global_buffer_pkg::addr_t];

    `include "glb_top_tb_cases.svh"

    glb_top #(.NUM_TILES(NUM_TILES)) glb_top_inst (
        .clk               (clk),
        .reset             (reset),
        .clk_en            (clk_en),
        .cfg_chain_len     (cfg_chain_len),
        .host_wr_en        (host_wr_en),
        .host_wr_addr      (host_wr_addr),
        .host_wr_data      (host_wr_data),
        .host_rd_en        (host_rd_en),
        .host_rd_addr      (host_rd_addr),
        .out_wr_en         (out_wr_en),
        .out_wr_addr       (out_wr_addr),
        .out_wr_data       (out_wr_data),
        .out_rd_en         (out_rd_en),
        .out_rd_addr       (out_rd_addr),
        .out_rd_data_valid (out_rd_data_valid),
        .out_rd_data       (out_rd_data)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    task automatic check_data(input string name, input string field,
                              input global_buffer_pkg::data_t exp,
                              input global_buffer_pkg::data_t act);
        if (act !== exp) begin
            $display("ERROR %s %s: expected %h, actual %h", name, field, exp, act);
            data_errors++;
        end
    endtask

    task automatic check_addr(input string name, input string field,
                              input global_buffer_pkg::addr_t exp,
                              input global_buffer_pkg::addr_t act);
        if (act !== exp) begin
            $display("ERROR %s %s: expected %h, actual %h", name, field, exp, act);
            data_errors++;
        end
    endtask

    task automatic check_flag(input string name, input string field,
                              input bit exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s %s: expected %b, actual %b", name, field, exp, act);
            flag_errors++;
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("ERROR %s latency: expected %0d, actual %0d", name, exp, act);
            latency_errors++;
        end
    endtask

    // host side back to an idle packet
    task automatic drive_idle();
        host_wr_en = 1'b0;
        host_wr_addr = '0;
        host_wr_data = '0;
        host_rd_en = 1'b0;
        host_rd_addr = '0;
    endtask

    // anything but an idle packet at the west edge, X counts as busy
    function automatic bit out_busy();
        return (out_wr_en !== 1'b0) || (out_rd_en !== 1'b0) || (out_rd_data_valid !== 1'b0);
    endfunction

    // upper address bits name the owning tile
    function automatic int tile_of(input global_buffer_pkg::addr_t addr);
        return int'(addr[global_buffer_pkg::ADDR_WIDTH-1 -:
                         global_buffer_pkg::TILE_SEL_ADDR_WIDTH]);
    endfunction

    task automatic check_reset_idle();
        repeat (IDLE_CYCLES) begin
            @(posedge clk);
            #1;
            check_flag("reset_idle", "out_wr_en", 1'b0, out_wr_en);
            check_flag("reset_idle", "out_rd_en", 1'b0, out_rd_en);
            check_flag("reset_idle", "out_rd_data_valid", 1'b0, out_rd_data_valid);
        end
    endtask

    // one packet in, wait for it at the west edge, compare
    task automatic run_row(input case_t row);
        global_buffer_pkg::data_t wr_data;
        global_buffer_pkg::data_t exp_data;
        int exp_latency;
        int limit;
        int cycles;
        bit returned;
        bit exp_busy;

        wr_data = row.rnd ? global_buffer_pkg::data_t'($urandom) : row.wr_data;
        exp_data = row.exp_data;
        // model lookup before the write, same tile reads see old data
        if (row.rnd && row.exp_valid) begin
            if (model_mem.exists(row.rd_addr)) begin
                exp_data = model_mem[row.rd_addr];
            end else begin
                $display("%s: reference model holds no word at address %h", row.name,
                         row.rd_addr);
                other_errors++;
            end
        end
        // only tiles inside the chain take the write
        if (row.wr_en && tile_of(row.wr_addr) < row.chain_len) begin
            model_mem[row.wr_addr] = wr_data;
        end
        // 2 cycles core pass, 1 pass-through, per active tile
        exp_latency = 3 * row.chain_len + row.stall;
        exp_busy = row.exp_wr_en || row.exp_rd_en || row.exp_valid;
        limit = exp_busy ? TIMEOUT_CYCLES : exp_latency;

        cfg_chain_len = global_buffer_pkg::tile_id_t'(row.chain_len);
        host_wr_en = row.wr_en;
        host_wr_addr = row.wr_addr;
        host_wr_data = wr_data;
        host_rd_en = row.rd_en;
        host_rd_addr = row.rd_addr;

        cycles = 0;
        returned = 1'b0;
        while (!returned && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
            // single cycle packet
            if (cycles == 1) begin
                drive_idle();
            end
            returned = out_busy();
            // freeze while the packet sits in tile 0's core stage
            if (row.stall > 0 && cycles == 1) begin
                clk_en = 1'b0;
            end
            if (row.stall > 0 && cycles == 1 + row.stall) begin
                clk_en = 1'b1;
            end
        end
        clk_en = 1'b1;

        if (!returned && exp_busy) begin
            $display("%s: no packet returned within %0d cycles", row.name, TIMEOUT_CYCLES);
            other_errors++;
        end else if (returned) begin
            check_latency(row.name, exp_latency, cycles);
            check_flag(row.name, "out_wr_en", row.exp_wr_en, out_wr_en);
            check_flag(row.name, "out_rd_en", row.exp_rd_en, out_rd_en);
            check_flag(row.name, "out_rd_data_valid", row.exp_valid, out_rd_data_valid);
            if (row.exp_valid) begin
                check_data(row.name, "out_rd_data", exp_data, out_rd_data);
            end
            // unserved requests keep their fields
            if (row.exp_rd_en) begin
                check_addr(row.name, "out_rd_addr", row.rd_addr, out_rd_addr);
            end
            if (row.exp_wr_en) begin
                check_addr(row.name, "out_wr_addr", row.wr_addr, out_wr_addr);
                check_data(row.name, "out_wr_data", wr_data, out_wr_data);
            end
        end
    endtask

    initial begin
        int total;

        void'($urandom(SEED));
        data_errors = 0;
        flag_errors = 0;
        latency_errors = 0;
        other_errors = 0;
        reset = 1'b1;
        clk_en = 1'b1;
        cfg_chain_len = global_buffer_pkg::tile_id_t'(NUM_TILES);
        drive_idle();
        load_cases();

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        check_reset_idle();
        foreach (cases[i]) begin
            run_row(cases[i]);
        end

        total = data_errors + flag_errors + latency_errors + other_errors;
        $display("error counts: data %0d, flag %0d, latency %0d, other %0d",
                 data_errors, flag_errors, latency_errors, other_errors);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/glb_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module glb_bank #(
    parameter int TILE_ID = 0
) (
    input  logic                          clk,
    input  logic                          clk_en,
    input  logic                          reset,

    // packet from the router, write side
    input  global_buffer_pkg::packet_t     packet_sr2sw,

    // read strobe from the read control
    input  logic                          rd_en,
    input  global_buffer_pkg::bank_addr_t  rd_addr,

    output global_buffer_pkg::data_t       bank_rd_data,
    output logic                          wr_hit
);

    localparam int DEPTH = 2 ** global_buffer_pkg::BANK_ADDR_WIDTH;
    localparam global_buffer_pkg::tile_id_t MY_TILE = global_buffer_pkg::tile_id_t'(TILE_ID);

    global_buffer_pkg::data_t      mem [DEPTH];
    global_buffer_pkg::tile_id_t   wr_tile;
    global_buffer_pkg::bank_addr_t wr_bank_addr;
    logic                          wr_sel;

    // split the write address into tile and word
    assign wr_tile = packet_sr2sw.wr_addr[global_buffer_pkg::ADDR_WIDTH-1 -:
                                          global_buffer_pkg::TILE_SEL_ADDR_WIDTH];
    assign wr_bank_addr = packet_sr2sw.wr_addr[global_buffer_pkg::BANK_ADDR_WIDTH-1:0];

    // write belongs to this bank
    assign wr_sel = packet_sr2sw.wr_en && (wr_tile == MY_TILE);

    // storage, read before write on the same address
    always_ff @(posedge clk) begin
        if (clk_en) begin
            if (wr_sel) begin
                mem[wr_bank_addr] <= packet_sr2sw.wr_data;
            end
            if (rd_en) begin
                bank_rd_data <= mem[rd_addr];
            end
        end
    end

    // hit flag lines up with the read data
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_hit <= 1'b0;
        end else if (clk_en) begin
            wr_hit <= wr_sel;
        end
    end

    // a frozen chain must leave the addressed word alone
    a_no_write_when_frozen : assert property (
        @(posedge clk) disable iff (reset)
        (!clk_en && wr_sel) |=> (mem[$past(wr_bank_addr)] === $past(mem[wr_bank_addr]))
    );

endmodule

`default_nettype wire

// ==== verilog/glb_core_pkt_merge.sv ====
`timescale 1ns/1ns
`default_nettype none

module glb_core_pkt_merge (
    input  global_buffer_pkg::packet_t packet_staged,
    input  logic                      rd_hit,
    input  logic                      wr_hit,
    input  global_buffer_pkg::data_t   bank_rd_data,
    output global_buffer_pkg::packet_t packet_sw2sr
);

    always_comb begin
        // default, packet passes as staged
        packet_sw2sr = packet_staged;

        // write done here, retire it
        if (wr_hit) begin
            packet_sw2sr.wr_en = 1'b0;
        end

        // read answered here
        if (rd_hit) begin
            packet_sw2sr.rd_en = 1'b0;
            packet_sw2sr.rd_data_valid = 1'b1;
            packet_sw2sr.rd_data = bank_rd_data;
        end
    end

    // answered reads leave the ring with rd_en cleared, at every tile
    always_comb begin
        a_rd_en_xor_valid : assert #0 (!(packet_sw2sr.rd_en === 1'b1 &&
                                         packet_sw2sr.rd_data_valid === 1'b1));
    end

endmodule

`default_nettype wire

// ==== verilog/glb_core_rd_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module glb_core_rd_ctrl #(
    parameter int TILE_ID = 0
) (
    input  logic                          clk,
    input  logic                          clk_en,
    input  logic                          reset,

    input  global_buffer_pkg::packet_t     packet_sr2sw,

    // bank read request
    output logic                          bank_rd_en,
    output global_buffer_pkg::bank_addr_t  bank_rd_addr,

    // staged packet aligned with bank data
    output global_buffer_pkg::packet_t     packet_staged,
    output logic                          rd_hit
);

    localparam global_buffer_pkg::tile_id_t MY_TILE = global_buffer_pkg::tile_id_t'(TILE_ID);

    global_buffer_pkg::tile_id_t rd_tile;

    // tile bits of the read address
    assign rd_tile = packet_sr2sw.rd_addr[global_buffer_pkg::ADDR_WIDTH-1 -:
                                          global_buffer_pkg::TILE_SEL_ADDR_WIDTH];

    // read only when this tile owns the address
    assign bank_rd_en = packet_sr2sw.rd_en && (rd_tile == MY_TILE);
    assign bank_rd_addr = packet_sr2sw.rd_addr[global_buffer_pkg::BANK_ADDR_WIDTH-1:0];

    // one cycle stage to match the bank read latency
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            packet_staged <= '0;
            rd_hit <= 1'b0;
        end else if (clk_en) begin
            packet_staged <= packet_sr2sw;
            rd_hit <= bank_rd_en;
        end
    end

    // a hit is for a packet that still asks for a read and has no answer yet
    a_hit_has_rd_en : assert property (
        @(posedge clk) disable iff (reset)
        rd_hit |-> (packet_staged.rd_en && !packet_staged.rd_data_valid)
    );

endmodule

`default_nettype wire

// ==== verilog/glb_core_strm_router.sv ====
`timescale 1ns/1ns
`default_nettype none

module glb_core_strm_router #(
    parameter int TILE_ID   = 0,
    parameter int NUM_TILES = 2
) (
    input  logic                      clk,
    input  logic                      clk_en,
    input  logic                      reset,

    // west side of the ring
    input  global_buffer_pkg::packet_t packet_w2e_wsti,
    output global_buffer_pkg::packet_t packet_e2w_wsto,

    // east side of the ring
    input  global_buffer_pkg::packet_t packet_e2w_esti,
    output global_buffer_pkg::packet_t packet_w2e_esto,

    // core side
    input  global_buffer_pkg::packet_t packet_sw2sr,
    output global_buffer_pkg::packet_t packet_sr2sw,

    // east link enable
    input  logic                      cfg_tile_connected_next
);

    // even tiles serve eastbound and odd tiles westbound
    localparam bit IS_EVEN = (TILE_ID % 2) == 0;

    global_buffer_pkg::packet_t packet_e2w_esti_turned;
    global_buffer_pkg::packet_t packet_pass_d1;
    global_buffer_pkg::packet_t packet_sw2sr_d1;
    global_buffer_pkg::packet_t packet_w2e_esto_int;
    global_buffer_pkg::packet_t packet_e2w_wsto_int;
    global_buffer_pkg::packet_t packet_pass_in;

    // at the end of the chain the eastbound stream comes straight back west
    assign packet_e2w_esti_turned = cfg_tile_connected_next ? packet_e2w_esti
                                                            : packet_w2e_esto_int;

    // the direction the core does not serve
    assign packet_pass_in = IS_EVEN ? packet_e2w_esti_turned : packet_w2e_wsti;

    // one stage for pass-through traffic
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            packet_pass_d1 <= '0;
        end else if (clk_en) begin
            packet_pass_d1 <= packet_pass_in;
        end
    end

    // core return stage before it rejoins the ring
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            packet_sw2sr_d1 <= '0;
        end else if (clk_en) begin
            packet_sw2sr_d1 <= packet_sw2sr;
        end
    end

    // switch between ring and core
    assign packet_sr2sw = IS_EVEN ? packet_w2e_wsti : packet_e2w_esti_turned;
    assign packet_w2e_esto_int = IS_EVEN ? packet_sw2sr_d1 : packet_pass_d1;
    assign packet_e2w_wsto_int = IS_EVEN ? packet_pass_d1 : packet_sw2sr_d1;

    // nothing travels past the last active tile
    assign packet_w2e_esto = cfg_tile_connected_next ? packet_w2e_esto_int : '0;
    assign packet_e2w_wsto = packet_e2w_wsto_int;

    // last built tile has nothing to its east
    a_last_tile_not_connected : assert property (
        @(posedge clk) disable iff (reset)
        (TILE_ID == NUM_TILES - 1) |-> !cfg_tile_connected_next
    );

endmodule

`default_nettype wire

// ==== verilog/glb_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module glb_top #(
    parameter int NUM_TILES = 4
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         clk_en,

    // number of active tiles, 1 to NUM_TILES
    input  global_buffer_pkg::tile_id_t   cfg_chain_len,

    // host request
    input  logic                         host_wr_en,
    input  global_buffer_pkg::addr_t      host_wr_addr,
    input  global_buffer_pkg::data_t      host_wr_data,
    input  logic                         host_rd_en,
    input  global_buffer_pkg::addr_t      host_rd_addr,

    // returned packet at the west edge of tile 0
    output logic                         out_wr_en,
    output global_buffer_pkg::addr_t      out_wr_addr,
    output global_buffer_pkg::data_t      out_wr_data,
    output logic                         out_rd_en,
    output global_buffer_pkg::addr_t      out_rd_addr,
    output logic                         out_rd_data_valid,
    output global_buffer_pkg::data_t      out_rd_data
);

    // w2e[i] enters tile i from the west, e2w[i] leaves tile i to the west
    global_buffer_pkg::packet_t w2e [NUM_TILES+1];
    global_buffer_pkg::packet_t e2w [NUM_TILES+1];
    logic [NUM_TILES-1:0]       cfg_tile_connected_next;

    // host packet, no read data yet
    assign w2e[0] = '{
        wr_en:         host_wr_en,
        wr_addr:       host_wr_addr,
        wr_data:       host_wr_data,
        rd_en:         host_rd_en,
        rd_addr:       host_rd_addr,
        rd_data_valid: 1'b0,
        rd_data:       '0
    };

    // last tile east input tied to its own east output, unused
    assign e2w[NUM_TILES] = w2e[NUM_TILES];

    // host side view
    assign out_wr_en         = e2w[0].wr_en;
    assign out_wr_addr       = e2w[0].wr_addr;
    assign out_wr_data       = e2w[0].wr_data;
    assign out_rd_en         = e2w[0].rd_en;
    assign out_rd_addr       = e2w[0].rd_addr;
    assign out_rd_data_valid = e2w[0].rd_data_valid;
    assign out_rd_data       = e2w[0].rd_data;

    for (genvar i = 0; i < NUM_TILES; i++) begin : g_tile
        global_buffer_pkg::packet_t    packet_sr2sw;
        global_buffer_pkg::packet_t    packet_sw2sr;
        global_buffer_pkg::packet_t    packet_staged;
        global_buffer_pkg::data_t      bank_rd_data;
        global_buffer_pkg::bank_addr_t bank_rd_addr;
        logic                          bank_rd_en;
        logic                          wr_hit;
        logic                          rd_hit;

        // east link live while the next tile is in the chain
        assign cfg_tile_connected_next[i] = (32'(i) + 32'd1) < 32'(cfg_chain_len);

        glb_core_strm_router #(.TILE_ID(i), .NUM_TILES(NUM_TILES)) router_inst (
            .clk                     (clk),
            .clk_en                  (clk_en),
            .reset                   (reset),
            .packet_w2e_wsti         (w2e[i]),
            .packet_e2w_wsto         (e2w[i]),
            .packet_e2w_esti         (e2w[i+1]),
            .packet_w2e_esto         (w2e[i+1]),
            .packet_sw2sr            (packet_sw2sr),
            .packet_sr2sw            (packet_sr2sw),
            .cfg_tile_connected_next (cfg_tile_connected_next[i])
        );

        glb_bank #(.TILE_ID(i)) bank_inst (
            .clk          (clk),
            .clk_en       (clk_en),
            .reset        (reset),
            .packet_sr2sw (packet_sr2sw),
            .rd_en        (bank_rd_en),
            .rd_addr      (bank_rd_addr),
            .bank_rd_data (bank_rd_data),
            .wr_hit       (wr_hit)
        );

        glb_core_rd_ctrl #(.TILE_ID(i)) rd_ctrl_inst (
            .clk           (clk),
            .clk_en        (clk_en),
            .reset         (reset),
            .packet_sr2sw  (packet_sr2sw),
            .bank_rd_en    (bank_rd_en),
            .bank_rd_addr  (bank_rd_addr),
            .packet_staged (packet_staged),
            .rd_hit        (rd_hit)
        );

        glb_core_pkt_merge pkt_merge_inst (
            .packet_staged (packet_staged),
            .rd_hit        (rd_hit),
            .wr_hit        (wr_hit),
            .bank_rd_data  (bank_rd_data),
            .packet_sw2sr  (packet_sw2sr)
        );
    end

endmodule

`default_nettype wire

// ==== verilog/global_buffer_pkg.sv ====
`default_nettype none

package global_buffer_pkg;

    // word width on the ring and in the banks
    localparam int DATA_WIDTH = 16;

    // upper address bits pick the tile, up to 16 tiles
    localparam int TILE_SEL_ADDR_WIDTH = 4;

    // word address inside one bank, 256 words
    localparam int BANK_ADDR_WIDTH = 8;

    // full word address
    localparam int ADDR_WIDTH = TILE_SEL_ADDR_WIDTH + BANK_ADDR_WIDTH;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [TILE_SEL_ADDR_WIDTH-1:0] tile_id_t;
    typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;

    // ring packet, all enables low means idle
    typedef struct packed {
        logic  wr_en;
        addr_t wr_addr;
        data_t wr_data;
        logic  rd_en;
        addr_t rd_addr;
        logic  rd_data_valid;
        data_t rd_data;
    } packet_t;

endpackage

`default_nettype wire
